//--- axi_lite_addr_decoder.sv
//**************************************************************************
// Routes one AXI4-Lite port to the control registers or L2, and answers
// unmapped addresses with SLVERR from a built-in error slave
//**************************************************************************
`timescale 1ns/1ps
`include "mempool_lite_defines.svh"

module axi_lite_addr_decoder (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  mempool_lite_pkg::axil_req_t s_req_i,
    output mempool_lite_pkg::axil_rsp_t s_rsp_o,
    output mempool_lite_pkg::axil_req_t ctrl_req_o,
    input  mempool_lite_pkg::axil_rsp_t ctrl_rsp_i,
    output mempool_lite_pkg::axil_req_t l2_req_o,
    input  mempool_lite_pkg::axil_rsp_t l2_rsp_i
);

    import mempool_lite_pkg::*;

    typedef enum logic [1:0] {
        SEL_CTRL,
        SEL_L2,
        SEL_ERR
    } sel_e;

    sel_e sel_q, sel;
    logic busy_q;
    logic start;
    logic done;
    logic [`ADDR_WIDTH-1:0] sel_addr;
    axil_req_t err_req;
    axil_rsp_t err_rsp;
    tgt_state_e err_state_q;

    function automatic sel_e decode(input logic [`ADDR_WIDTH-1:0] addr);
        if (addr >= `CTRL_BASE && addr < `CTRL_BASE + `CTRL_SIZE) begin
            return SEL_CTRL;
        end
        if (addr >= `L2_BASE && addr < `L2_BASE + `L2_SIZE) begin
            return SEL_L2;
        end
        return SEL_ERR;
    endfunction

    function automatic axil_req_t gate_req(input axil_req_t req, input logic en);
        axil_req_t gated;
        gated          = req;
        gated.aw_valid = req.aw_valid && en;
        gated.w_valid  = req.w_valid && en;
        gated.b_ready  = req.b_ready && en;
        gated.ar_valid = req.ar_valid && en;
        gated.r_ready  = req.r_ready && en;
        return gated;
    endfunction

    assign sel_addr = s_req_i.aw_valid ? s_req_i.aw_addr : s_req_i.ar_addr;
    assign sel      = busy_q ? sel_q : decode(sel_addr);

    assign ctrl_req_o = gate_req(s_req_i, sel == SEL_CTRL);
    assign l2_req_o   = gate_req(s_req_i, sel == SEL_L2);
    assign err_req    = gate_req(s_req_i, sel == SEL_ERR);

    always_comb begin
        case (sel)
            SEL_CTRL: s_rsp_o = ctrl_rsp_i;
            SEL_L2:   s_rsp_o = l2_rsp_i;
            default:  s_rsp_o = err_rsp;
        endcase
    end

    assign start = (s_req_i.aw_valid && s_rsp_o.aw_ready) ||
                   (s_req_i.ar_valid && s_rsp_o.ar_ready);
    assign done  = (s_rsp_o.b_valid && s_req_i.b_ready) ||
                   (s_rsp_o.r_valid && s_req_i.r_ready);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            sel_q  <= SEL_ERR;
        end else if (!busy_q && start) begin
            busy_q <= 1'b1;
            sel_q  <= sel;
        end else if (busy_q && done) begin
            busy_q <= 1'b0;
        end
    end

    // Error slave, same timing as a real target
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            err_state_q <= TGT_IDLE;
        end else begin
            case (err_state_q)
                TGT_IDLE: begin
                    if (err_req.aw_valid) begin
                        err_state_q <= TGT_WDATA;
                    end else if (err_req.ar_valid) begin
                        err_state_q <= TGT_RRESP;
                    end
                end
                TGT_WDATA: begin
                    if (err_req.w_valid) begin
                        err_state_q <= TGT_BRESP;
                    end
                end
                TGT_BRESP: begin
                    if (err_req.b_ready) begin
                        err_state_q <= TGT_IDLE;
                    end
                end
                default: begin
                    if (err_req.r_ready) begin
                        err_state_q <= TGT_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        err_rsp          = '0;   // Read data stays zero
        err_rsp.aw_ready = (err_state_q == TGT_IDLE);
        err_rsp.ar_ready = (err_state_q == TGT_IDLE) && !err_req.aw_valid;
        err_rsp.w_ready  = (err_state_q == TGT_WDATA);
        err_rsp.b_resp   = SLVERR;
        err_rsp.b_valid  = (err_state_q == TGT_BRESP);
        err_rsp.r_resp   = SLVERR;
        err_rsp.r_valid  = (err_state_q == TGT_RRESP);
    end

endmodule

//--- axi_lite_arbiter.sv
//**************************************************************************
// Fixed-priority arbiter, two AXI4-Lite masters onto one slave
// Master 0 wins when idle; the grant is held for a whole transaction
//**************************************************************************
`timescale 1ns/1ps

module axi_lite_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  mempool_lite_pkg::axil_req_t m0_req_i,
    output mempool_lite_pkg::axil_rsp_t m0_rsp_o,
    input  mempool_lite_pkg::axil_req_t m1_req_i,
    output mempool_lite_pkg::axil_rsp_t m1_rsp_o,
    output mempool_lite_pkg::axil_req_t s_req_o,
    input  mempool_lite_pkg::axil_rsp_t s_rsp_i
);

    import mempool_lite_pkg::*;

    logic grant_q;
    logic busy_q;
    logic gnt;
    logic m0_start;
    logic m1_start;
    logic done;

    function automatic axil_rsp_t gate_rsp(input axil_rsp_t rsp, input logic en);
        axil_rsp_t gated;
        gated          = rsp;
        gated.aw_ready = rsp.aw_ready && en;
        gated.w_ready  = rsp.w_ready && en;
        gated.ar_ready = rsp.ar_ready && en;
        gated.b_valid  = rsp.b_valid && en;
        gated.r_valid  = rsp.r_valid && en;
        return gated;
    endfunction

    assign m0_start = m0_req_i.aw_valid || m0_req_i.ar_valid;
    assign m1_start = m1_req_i.aw_valid || m1_req_i.ar_valid;

    assign gnt      = busy_q ? grant_q : (!m0_start && m1_start);
    assign s_req_o  = gnt ? m1_req_i : m0_req_i;
    assign m0_rsp_o = gate_rsp(s_rsp_i, !gnt);
    assign m1_rsp_o = gate_rsp(s_rsp_i, gnt);

    assign done = (s_rsp_i.b_valid && s_req_o.b_ready) ||
                  (s_rsp_i.r_valid && s_req_o.r_ready);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q  <= 1'b0;
            grant_q <= 1'b0;
        end else if (!busy_q) begin
            if (m0_start || m1_start) begin
                busy_q  <= 1'b1;
                grant_q <= gnt;
            end
        end else if (done) begin
            busy_q <= 1'b0;   // Free again next cycle
        end
    end

    // A slave response only comes back while the grant is held
    a_grant_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        s_rsp_i.b_valid || s_rsp_i.r_valid |-> busy_q);

endmodule

//--- boot_sim_ctrl.sv
//**************************************************************************
// Boot controller: waits out the boot ROM, writes the wake-up register,
// then raises fetch once the write returns OKAY
//**************************************************************************
`timescale 1ns/1ps
`include "mempool_lite_defines.svh"

module boot_sim_ctrl (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    output mempool_lite_pkg::axil_req_t req_o,
    input  mempool_lite_pkg::axil_rsp_t rsp_i,
    output logic                        fetch_o
);

    import mempool_lite_pkg::*;

    localparam int cnt_w = $clog2(`BOOT_DELAY + 1);
    localparam logic [`ADDR_WIDTH-1:0] wake_addr = `CTRL_BASE + `REG_WAKE_UP;

    boot_state_e state_q, state_d;
    logic [cnt_w-1:0] cnt_q, cnt_d;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        req_o   = '0;
        case (state_q)
            IDLE: begin
                state_d = WAIT_BOOTROM;
            end
            WAIT_BOOTROM: begin
                cnt_d = cnt_q + 1'b1;
                if (cnt_q == cnt_w'(`BOOT_DELAY)) begin
                    state_d = WAKE_UP_AW;
                end
            end
            WAKE_UP_AW: begin
                req_o.aw_addr  = wake_addr;
                req_o.aw_valid = 1'b1;
                if (rsp_i.aw_ready) begin
                    state_d = WAKE_UP_W;
                end
            end
            WAKE_UP_W: begin
                req_o.w_data  = '1;   // Wake every core
                req_o.w_strb  = '1;
                req_o.w_valid = 1'b1;
                if (rsp_i.w_ready) begin
                    state_d = WAKE_UP_B;
                end
            end
            WAKE_UP_B: begin
                req_o.b_ready = 1'b1;
                if (rsp_i.b_valid) begin
                    state_d = (rsp_i.b_resp == OKAY) ? DONE : BOOT_ERR;
                end
            end
            default: begin
            end
        endcase
    end

    assign fetch_o = (state_q == DONE);

    // The wake-up address must stay posted until the slave takes it
    a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_o.aw_valid && !rsp_i.aw_ready |=> req_o.aw_valid && $stable(req_o.aw_addr));

endmodule

//--- ctrl_regs.sv
//**************************************************************************
// Control region: boot address, wake-up, scratch and core-count registers
// Writing WAKE_UP pulses the written mask on wake_o for one cycle
//**************************************************************************
`timescale 1ns/1ps
`include "mempool_lite_defines.svh"

module ctrl_regs (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  mempool_lite_pkg::axil_req_t req_i,
    output mempool_lite_pkg::axil_rsp_t rsp_o,
    output logic [`NUM_CORES-1:0]       wake_o,
    output logic [`ADDR_WIDTH-1:0]      boot_addr_o
);

    import mempool_lite_pkg::*;

    localparam int off_w = $clog2(`CTRL_SIZE);
    localparam logic [off_w-1:0] off_boot    = off_w'(`REG_BOOT_ADDR);
    localparam logic [off_w-1:0] off_wake    = off_w'(`REG_WAKE_UP);
    localparam logic [off_w-1:0] off_scratch = off_w'(`REG_SCRATCH);
    localparam logic [off_w-1:0] off_cores   = off_w'(`REG_NUM_CORES);

    tgt_state_e state_q;
    logic aw_hs, w_hs, ar_hs;
    logic [off_w-1:0] wr_off_q;
    logic [off_w-1:0] rd_off;
    logic [`ADDR_WIDTH-1:0] boot_addr_q;
    logic [`DATA_WIDTH-1:0] scratch_q;
    logic [`NUM_CORES-1:0] wake_q;
    logic [`DATA_WIDTH-1:0] rd_data, r_data_q;
    axil_resp_e rd_resp, wr_resp, r_resp_q, b_resp_q;

    assign aw_hs  = (state_q == TGT_IDLE) && req_i.aw_valid;
    assign ar_hs  = (state_q == TGT_IDLE) && !req_i.aw_valid && req_i.ar_valid;
    assign w_hs   = (state_q == TGT_WDATA) && req_i.w_valid;
    assign rd_off = req_i.ar_addr[off_w-1:0];

    always_comb begin
        rd_data = '0;
        rd_resp = OKAY;
        case (rd_off)
            off_boot:    rd_data = boot_addr_q;
            off_wake:    rd_data = '0;
            off_scratch: rd_data = scratch_q;
            off_cores:   rd_data = `DATA_WIDTH'(`NUM_CORES);
            default:     rd_resp = SLVERR;
        endcase
    end

    assign wr_resp = (wr_off_q inside {off_boot, off_wake, off_scratch, off_cores}) ?
                     OKAY : SLVERR;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= TGT_IDLE;
            boot_addr_q <= `BOOT_ADDR_RESET;
            scratch_q   <= '0;
            wake_q      <= '0;
        end else begin
            wake_q <= '0;
            case (state_q)
                TGT_IDLE:  state_q <= aw_hs ? TGT_WDATA : (ar_hs ? TGT_RRESP : TGT_IDLE);
                TGT_WDATA: state_q <= w_hs ? TGT_BRESP : TGT_WDATA;
                TGT_BRESP: state_q <= req_i.b_ready ? TGT_IDLE : TGT_BRESP;
                default:   state_q <= req_i.r_ready ? TGT_IDLE : TGT_RRESP;
            endcase
            if (w_hs) begin
                case (wr_off_q)
                    off_boot:    boot_addr_q <= apply_strb(boot_addr_q, req_i.w_data, req_i.w_strb);
                    off_wake:    wake_q <= req_i.w_data[`NUM_CORES-1:0];
                    off_scratch: scratch_q <= apply_strb(scratch_q, req_i.w_data, req_i.w_strb);
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            wr_off_q <= req_i.aw_addr[off_w-1:0];
        end
        if (w_hs) begin
            b_resp_q <= wr_resp;
        end
        if (ar_hs) begin
            r_data_q <= rd_data;
            r_resp_q <= rd_resp;
        end
    end

    always_comb begin
        rsp_o          = '0;
        rsp_o.aw_ready = (state_q == TGT_IDLE);
        rsp_o.ar_ready = (state_q == TGT_IDLE) && !req_i.aw_valid;
        rsp_o.w_ready  = (state_q == TGT_WDATA);
        rsp_o.b_resp   = b_resp_q;
        rsp_o.b_valid  = (state_q == TGT_BRESP);
        rsp_o.r_data   = r_data_q;
        rsp_o.r_resp   = r_resp_q;
        rsp_o.r_valid  = (state_q == TGT_RRESP);
    end

    assign wake_o      = wake_q;
    assign boot_addr_o = boot_addr_q;

endmodule

//--- l2_mem.sv
//**************************************************************************
// L2 memory on AXI4-Lite, word addressed with byte-strobe writes
//**************************************************************************
`timescale 1ns/1ps
`include "mempool_lite_defines.svh"

module l2_mem (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  mempool_lite_pkg::axil_req_t req_i,
    output mempool_lite_pkg::axil_rsp_t rsp_o
);

    import mempool_lite_pkg::*;

    localparam int idx_w = $clog2(`L2_WORDS);
    localparam int lsb   = $clog2(`STRB_WIDTH);

    tgt_state_e state_q;
    logic aw_hs, w_hs, ar_hs;
    logic [idx_w-1:0] widx_q;
    logic [`DATA_WIDTH-1:0] r_data_q;
    logic [`DATA_WIDTH-1:0] mem_q [`L2_WORDS];

    assign aw_hs = (state_q == TGT_IDLE) && req_i.aw_valid;
    assign ar_hs = (state_q == TGT_IDLE) && !req_i.aw_valid && req_i.ar_valid;
    assign w_hs  = (state_q == TGT_WDATA) && req_i.w_valid;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= TGT_IDLE;
        end else begin
            case (state_q)
                TGT_IDLE:  state_q <= aw_hs ? TGT_WDATA : (ar_hs ? TGT_RRESP : TGT_IDLE);
                TGT_WDATA: state_q <= w_hs ? TGT_BRESP : TGT_WDATA;
                TGT_BRESP: state_q <= req_i.b_ready ? TGT_IDLE : TGT_BRESP;
                default:   state_q <= req_i.r_ready ? TGT_IDLE : TGT_RRESP;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            widx_q <= req_i.aw_addr[lsb +: idx_w];   // Wraps inside the region
        end
        if (w_hs) begin
            mem_q[widx_q] <= apply_strb(mem_q[widx_q], req_i.w_data, req_i.w_strb);
        end
        if (ar_hs) begin
            r_data_q <= mem_q[req_i.ar_addr[lsb +: idx_w]];
        end
    end

    always_comb begin
        rsp_o          = '0;
        rsp_o.aw_ready = (state_q == TGT_IDLE);
        rsp_o.ar_ready = (state_q == TGT_IDLE) && !req_i.aw_valid;
        rsp_o.w_ready  = (state_q == TGT_WDATA);
        rsp_o.b_resp   = OKAY;
        rsp_o.b_valid  = (state_q == TGT_BRESP);
        rsp_o.r_data   = r_data_q;
        rsp_o.r_resp   = OKAY;
        rsp_o.r_valid  = (state_q == TGT_RRESP);
    end

endmodule

//--- mempool_lite_defines.svh
//**************************************************************************
// Widths, address map and boot timing of the MemPool-lite system slice
// Include wherever one of these values is needed
//**************************************************************************
`ifndef MEMPOOL_LITE_DEFINES_SVH
`define MEMPOOL_LITE_DEFINES_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define STRB_WIDTH (`DATA_WIDTH / 8)

`define CTRL_BASE 32'h4000_0000
`define CTRL_SIZE 32'h0100_0000
`define L2_BASE   32'h8000_0000
`define L2_SIZE   32'h0700_0000
`define L2_WORDS  256             // Implemented depth, wraps in region

`define BOOT_DELAY 64
`define NUM_CORES  16

`define REG_BOOT_ADDR 32'h0000_0000
`define REG_WAKE_UP   32'h0000_0004
`define REG_SCRATCH   32'h0000_0008
`define REG_NUM_CORES 32'h0000_000C

`define BOOT_ADDR_RESET 32'h8000_0000

`endif

//--- mempool_lite_pkg.sv
//**************************************************************************
// AXI4-Lite channel types, response codes and FSM states of the slice
// Import into every module that uses the link types
//**************************************************************************
`include "mempool_lite_defines.svh"

package mempool_lite_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_e;

    typedef struct packed {
        logic [`ADDR_WIDTH-1:0] aw_addr;
        logic                   aw_valid;
        logic [`DATA_WIDTH-1:0] w_data;
        logic [`STRB_WIDTH-1:0] w_strb;
        logic                   w_valid;
        logic                   b_ready;
        logic [`ADDR_WIDTH-1:0] ar_addr;
        logic                   ar_valid;
        logic                   r_ready;
    } axil_req_t;

    typedef struct packed {
        logic                   aw_ready;
        logic                   w_ready;
        axil_resp_e             b_resp;
        logic                   b_valid;
        logic                   ar_ready;
        logic [`DATA_WIDTH-1:0] r_data;
        axil_resp_e             r_resp;
        logic                   r_valid;
    } axil_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_BOOTROM,
        WAKE_UP_AW,
        WAKE_UP_W,
        WAKE_UP_B,
        DONE,
        BOOT_ERR
    } boot_state_e;

    // Handshake state of a single-transaction slave
    typedef enum logic [1:0] {
        TGT_IDLE,
        TGT_WDATA,
        TGT_BRESP,
        TGT_RRESP
    } tgt_state_e;

    function automatic logic [`DATA_WIDTH-1:0] apply_strb(
        input logic [`DATA_WIDTH-1:0] old_data,
        input logic [`DATA_WIDTH-1:0] new_data,
        input logic [`STRB_WIDTH-1:0] strb
    );
        logic [`DATA_WIDTH-1:0] merged;
        merged = old_data;
        for (int i = 0; i < `STRB_WIDTH; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_data[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- mempool_sys_top.sv
//**************************************************************************
// System slice top: boot controller and host port share one bus
//**************************************************************************
`timescale 1ns/1ps
`include "mempool_lite_defines.svh"

module mempool_sys_top (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  mempool_lite_pkg::axil_req_t host_req_i,
    output mempool_lite_pkg::axil_rsp_t host_rsp_o,
    output logic                        fetch_o,
    output logic [`NUM_CORES-1:0]       wake_o,
    output logic [`ADDR_WIDTH-1:0]      boot_addr_o
);

    import mempool_lite_pkg::*;

    axil_req_t boot_req, bus_req, ctrl_req, l2_req;
    axil_rsp_t boot_rsp, bus_rsp, ctrl_rsp, l2_rsp;

    boot_sim_ctrl boot_sim_ctrl_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_o   (boot_req),
        .rsp_i   (boot_rsp),
        .fetch_o (fetch_o)
    );

    axi_lite_arbiter axi_lite_arbiter_i (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .m0_req_i (boot_req),
        .m0_rsp_o (boot_rsp),
        .m1_req_i (host_req_i),   // Host has the lower priority
        .m1_rsp_o (host_rsp_o),
        .s_req_o  (bus_req),
        .s_rsp_i  (bus_rsp)
    );

    axi_lite_addr_decoder axi_lite_addr_decoder_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .s_req_i    (bus_req),
        .s_rsp_o    (bus_rsp),
        .ctrl_req_o (ctrl_req),
        .ctrl_rsp_i (ctrl_rsp),
        .l2_req_o   (l2_req),
        .l2_rsp_i   (l2_rsp)
    );

    ctrl_regs ctrl_regs_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (ctrl_req),
        .rsp_o       (ctrl_rsp),
        .wake_o      (wake_o),
        .boot_addr_o (boot_addr_o)
    );

    l2_mem l2_mem_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .req_i   (l2_req),
        .rsp_o   (l2_rsp)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_mempool_sys -f sources.f -o tb_mempool_sys
./obj_dir/tb_mempool_sys | tee sim.log
if grep -q "^PASS: all tests$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- sources.f
+incdir+.
mempool_lite_pkg.sv
boot_sim_ctrl.sv
axi_lite_arbiter.sv
axi_lite_addr_decoder.sv
ctrl_regs.sv
l2_mem.sv
mempool_sys_top.sv
tb_mempool_sys.sv

//--- tb_mempool_sys.sv
//**************************************************************************
// Directed testbench of the MemPool-lite slice that drives the host port
// and checks boot, L2, control registers and decode errors
//**************************************************************************
`timescale 1ns/1ps
`include "mempool_lite_defines.svh"

module tb_mempool_sys;

    import mempool_lite_pkg::*;

    localparam int num_tests   = 6;
    localparam int cycle_limit = (`BOOT_DELAY + 200) * num_tests;

    logic clk = 1'b0;
    logic rst_n;
    axil_req_t host_req;
    axil_rsp_t host_rsp;
    logic fetch;
    logic [`NUM_CORES-1:0] wake;
    logic [`ADDR_WIDTH-1:0] boot_addr;

    logic [31:0] lfsr_state = 32'd97;
    int cycle_cnt = 0;
    int wake_cnt = 0;
    logic [`NUM_CORES-1:0] wake_last = '0;
    logic wake_fetch = 1'b0;
    logic [`DATA_WIDTH-1:0] l2_model [`L2_WORDS];
    logic [`ADDR_WIDTH-1:0] l2_used [$];

    mempool_sys_top mempool_sys_top_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .host_req_i  (host_req),
        .host_rsp_o  (host_rsp),
        .fetch_o     (fetch),
        .wake_o      (wake),
        .boot_addr_o (boot_addr)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles, the run did not finish", cycle_cnt));
        end
    end

    // Wake pulse monitor
    always @(posedge clk) begin
        if (rst_n && wake != '0) begin
            wake_cnt   <= wake_cnt + 1;
            wake_last  <= wake;
            wake_fetch <= fetch;   // Fetch state at the pulse
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_resp(input string name, input axil_resp_e got, input axil_resp_e exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_data(input string name, input logic [`DATA_WIDTH-1:0] got,
                              input logic [`DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_wake(input string name, input logic [`NUM_CORES-1:0] got,
                              input logic [`NUM_CORES-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] lfsr_take(input int nbits);
        logic [31:0] bits;
        logic        out;
        bits = '0;
        for (int i = 0; i < nbits; i++) begin
            out        = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (out ? 32'hD000_0001 : 32'h0);
            bits       = {bits[30:0], out};
        end
        return bits;
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] merge_bytes(input logic [`DATA_WIDTH-1:0] old_word,
                                                           input logic [`DATA_WIDTH-1:0] new_word,
                                                           input logic [`STRB_WIDTH-1:0] strb);
        logic [`DATA_WIDTH-1:0] keep;
        keep = '0;
        for (int b = 0; b < `STRB_WIDTH; b++) begin
            keep[8*b +: 8] = {8{strb[b]}};
        end
        return (old_word & ~keep) | (new_word & keep);
    endfunction

    function automatic int model_index(input logic [`ADDR_WIDTH-1:0] addr);
        return int'(((addr - `L2_BASE) >> 2) % `L2_WORDS);   // Word wraps inside L2
    endfunction

    task automatic axil_write(input logic [`ADDR_WIDTH-1:0] addr,
                              input logic [`DATA_WIDTH-1:0] data,
                              input logic [`STRB_WIDTH-1:0] strb, output axil_resp_e resp);
        host_req.aw_addr  <= addr;
        host_req.aw_valid <= 1'b1;
        @(posedge clk);
        while (!host_rsp.aw_ready) @(posedge clk);
        host_req.aw_valid <= 1'b0;
        host_req.w_data   <= data;
        host_req.w_strb   <= strb;
        host_req.w_valid  <= 1'b1;
        @(posedge clk);
        while (!host_rsp.w_ready) @(posedge clk);
        host_req.w_valid <= 1'b0;
        host_req.b_ready <= 1'b1;
        @(posedge clk);
        while (!host_rsp.b_valid) @(posedge clk);
        host_req.b_ready <= 1'b0;
        resp = host_rsp.b_resp;
    endtask

    task automatic axil_read(input logic [`ADDR_WIDTH-1:0] addr,
                             output logic [`DATA_WIDTH-1:0] data, output axil_resp_e resp);
        host_req.ar_addr  <= addr;
        host_req.ar_valid <= 1'b1;
        @(posedge clk);
        while (!host_rsp.ar_ready) @(posedge clk);
        host_req.ar_valid <= 1'b0;
        host_req.r_ready  <= 1'b1;
        @(posedge clk);
        while (!host_rsp.r_valid) @(posedge clk);
        host_req.r_ready <= 1'b0;
        data = host_rsp.r_data;
        resp = host_rsp.r_resp;
    endtask

    task automatic write_read_l2(input logic [`ADDR_WIDTH-1:0] addr, input logic full_word);
        logic [`DATA_WIDTH-1:0] data;
        logic [`DATA_WIDTH-1:0] rdata;
        logic [`STRB_WIDTH-1:0] strb;
        axil_resp_e resp;
        int idx;
        data = lfsr_take(`DATA_WIDTH);
        strb = full_word ? '1 : `STRB_WIDTH'(lfsr_take(`STRB_WIDTH));
        idx  = model_index(addr);
        axil_write(addr, data, strb, resp);
        check_resp("b_resp", resp, OKAY);
        l2_model[idx] = merge_bytes(l2_model[idx], data, strb);
        axil_read(addr, rdata, resp);
        check_resp("r_resp", resp, OKAY);
        check_data("r_data", rdata, l2_model[idx]);
    endtask

    task automatic recheck_l2();
        logic [`DATA_WIDTH-1:0] rdata;
        axil_resp_e resp;
        foreach (l2_used[i]) begin
            axil_read(l2_used[i], rdata, resp);
            check_resp("r_resp", resp, OKAY);
            check_data("r_data", rdata, l2_model[model_index(l2_used[i])]);
        end
    endtask

    task automatic after_reset();
        logic [`DATA_WIDTH-1:0] rdata;
        axil_resp_e resp;
        check_bit("fetch_o", fetch, 1'b0);
        check_wake("wake_o", wake, '0);
        axil_read(`CTRL_BASE + `REG_BOOT_ADDR, rdata, resp);
        check_resp("r_resp", resp, OKAY);
        check_data("boot_addr", rdata, `BOOT_ADDR_RESET);
        axil_read(`CTRL_BASE + `REG_NUM_CORES, rdata, resp);
        check_resp("r_resp", resp, OKAY);
        check_data("num_cores", rdata, `DATA_WIDTH'(`NUM_CORES));
    endtask

    task automatic boot_sequence();
        logic [`ADDR_WIDTH-1:0] addr;
        while (!fetch) begin   // Keep the bus busy while booting
            addr = `L2_BASE + (lfsr_take(8) << 2);
            write_read_l2(addr, 1'b1);
            l2_used.push_back(addr);
        end
        if (wake_cnt != 1) begin
            abort_run($sformatf("Expected one wake_o pulse before fetch_o, saw %0d", wake_cnt));
        end
        if (wake_fetch) begin
            abort_run("The wake_o pulse came after fetch_o was already high");
        end
        check_wake("wake_o", wake_last, '1);
    endtask

    task automatic l2_data();
        logic [`ADDR_WIDTH-1:0] addr;
        for (int i = 0; i < 6; i++) begin
            addr = `L2_BASE + (lfsr_take(8) << 2);
            if (i == 5) begin
                addr = `L2_BASE + 32'h0123_4560;   // Beyond the implemented depth
            end
            write_read_l2(addr, 1'b1);
            write_read_l2(addr, 1'b0);
            write_read_l2(addr, 1'b0);
            l2_used.push_back(addr);
        end
        for (int i = 0; i < l2_used.size() && i < 4; i++) begin
            write_read_l2(l2_used[i], 1'b0);
        end
    endtask

    task automatic ctrl_registers();
        logic [`DATA_WIDTH-1:0] data;
        logic [`DATA_WIDTH-1:0] rdata;
        logic [`DATA_WIDTH-1:0] expv;
        logic [`STRB_WIDTH-1:0] strb;
        axil_resp_e resp;
        data = lfsr_take(`DATA_WIDTH);
        axil_write(`CTRL_BASE + `REG_SCRATCH, data, '1, resp);
        check_resp("b_resp", resp, OKAY);
        expv = data;
        data = lfsr_take(`DATA_WIDTH);
        strb = `STRB_WIDTH'(lfsr_take(`STRB_WIDTH));
        axil_write(`CTRL_BASE + `REG_SCRATCH, data, strb, resp);
        check_resp("b_resp", resp, OKAY);
        expv = merge_bytes(expv, data, strb);
        axil_read(`CTRL_BASE + `REG_SCRATCH, rdata, resp);
        check_resp("r_resp", resp, OKAY);
        check_data("scratch", rdata, expv);
        data = lfsr_take(`DATA_WIDTH);
        strb = `STRB_WIDTH'(lfsr_take(`STRB_WIDTH));
        axil_write(`CTRL_BASE + `REG_BOOT_ADDR, data, strb, resp);
        check_resp("b_resp", resp, OKAY);
        expv = merge_bytes(`BOOT_ADDR_RESET, data, strb);
        axil_read(`CTRL_BASE + `REG_BOOT_ADDR, rdata, resp);
        check_resp("r_resp", resp, OKAY);
        check_data("boot_addr", rdata, expv);
        check_data("boot_addr_o", boot_addr, expv);
        axil_write(`CTRL_BASE + `REG_NUM_CORES, lfsr_take(`DATA_WIDTH), '1, resp);
        check_resp("b_resp", resp, OKAY);
        axil_read(`CTRL_BASE + `REG_NUM_CORES, rdata, resp);
        check_resp("r_resp", resp, OKAY);
        check_data("num_cores", rdata, `DATA_WIDTH'(`NUM_CORES));
        axil_write(`CTRL_BASE + 32'h10, lfsr_take(`DATA_WIDTH), '1, resp);
        check_resp("b_resp", resp, SLVERR);
        axil_read(`CTRL_BASE + 32'h10, rdata, resp);
        check_resp("r_resp", resp, SLVERR);
    endtask

    task automatic decode_errors();
        logic [`ADDR_WIDTH-1:0] bad_addr [2];
        logic [`ADDR_WIDTH-1:0] alias_addr;
        logic [`DATA_WIDTH-1:0] rdata;
        axil_resp_e resp;
        bad_addr[0] = 32'h0000_1000;
        bad_addr[1] = 32'hC000_0000;
        foreach (bad_addr[i]) begin
            alias_addr = `L2_BASE + (bad_addr[i] % (4 * `L2_WORDS));   // L2 word a leak would hit
            write_read_l2(alias_addr, 1'b1);
            l2_used.push_back(alias_addr);
            axil_write(bad_addr[i], lfsr_take(`DATA_WIDTH), '1, resp);
            check_resp("b_resp", resp, SLVERR);
            axil_read(bad_addr[i], rdata, resp);
            check_resp("r_resp", resp, SLVERR);
            check_data("r_data", rdata, '0);
        end
        recheck_l2();   // Nothing leaked into L2
    endtask

    task automatic host_wake_up();
        logic [`DATA_WIDTH-1:0] mask;
        axil_resp_e resp;
        int cnt_before;
        mask = lfsr_take(`DATA_WIDTH);
        while (mask[`NUM_CORES-1:0] == '0) begin
            mask = lfsr_take(`DATA_WIDTH);
        end
        cnt_before = wake_cnt;
        axil_write(`CTRL_BASE + `REG_WAKE_UP, mask, '1, resp);
        check_resp("b_resp", resp, OKAY);
        repeat (4) @(posedge clk);
        if (wake_cnt != cnt_before + 1) begin
            abort_run($sformatf("Expected one wake_o pulse from the host write, saw %0d",
                                wake_cnt - cnt_before));
        end
        check_wake("wake_o", wake_last, mask[`NUM_CORES-1:0]);
        check_bit("fetch_o", fetch, 1'b1);
    endtask

    initial begin
        host_req = '0;
        rst_n    = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        after_reset();
        boot_sequence();
        l2_data();
        ctrl_registers();
        decode_errors();
        host_wake_up();
        $display("PASS: all tests");
        $finish;
    end

endmodule
